/* rtl/bedrock_pkg.sv */
/*
  Reduced single-beat memory message format shared by all blocks.
  Every message is one beat, so there is no "last" signal on any link.
  Packed layout of mem_msg_s, msb first, is op[55:54] size[53:52]
  addr[51:32] data[31:0]. Boot image lines use this layout as 14 hex digits.
  Address bits split into device id, register index and byte offset.
*/
package bedrock_pkg;

  localparam int unsigned DEV_ID_WIDTH  = 4;
  localparam int unsigned REG_IDX_WIDTH = 12;
  localparam int unsigned OFFSET_WIDTH  = 4;
  localparam int unsigned ADDR_WIDTH    = DEV_ID_WIDTH + REG_IDX_WIDTH + OFFSET_WIDTH;
  localparam int unsigned DATA_WIDTH    = 32;

  typedef enum logic [1:0] {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } mem_op_e;

  typedef enum logic [1:0] {
    e_size_byte = 2'b00,
    e_size_half = 2'b01,
    e_size_word = 2'b10
  } mem_size_e;

  typedef struct packed {
    logic [DEV_ID_WIDTH-1:0]  dev_id;
    logic [REG_IDX_WIDTH-1:0] reg_idx;
    logic [OFFSET_WIDTH-1:0]  offset;
  } mem_addr_fields_s;

  // Same 20 bits, flat for routing or split for device decode
  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    mem_addr_fields_s      fields;
  } mem_addr_u;

  typedef struct packed {
    mem_op_e   op;
    mem_size_e size;
    mem_addr_u addr;
  } mem_header_s;

  typedef struct packed {
    mem_header_s           header;
    logic [DATA_WIDTH-1:0] data;
  } mem_msg_s;

endpackage

/* rtl/host_map_pkg.sv */
/*
  Host device address map and subsystem sizing.
  Finish registers sit at consecutive indices starting at REG_FINISH_BASE.
  NBF_DEPTH and SRC_FIFO_DEPTH must be powers of two, since the loader
  and arbiter pointers wrap by overflow.
*/
package host_map_pkg;

  localparam logic [bedrock_pkg::DEV_ID_WIDTH-1:0] HOST_DEV_ID = 4'h1;

  localparam int unsigned NUM_CORE       = 4;
  localparam int unsigned CORE_IDX_WIDTH = $clog2(NUM_CORE);

  // Register indices within the host device
  localparam logic [bedrock_pkg::REG_IDX_WIDTH-1:0] REG_FINISH_BASE = 12'h010;
  localparam logic [bedrock_pkg::REG_IDX_WIDTH-1:0] REG_ENABLE      = 12'h020;
  localparam logic [bedrock_pkg::REG_IDX_WIDTH-1:0] REG_PUTCHAR     = 12'h030;

  // Enable register bits
  localparam int unsigned EN_ICACHE    = 0;
  localparam int unsigned EN_DCACHE    = 1;
  localparam int unsigned EN_CMT       = 2;
  localparam int unsigned EN_COSIM     = 3;
  localparam int unsigned ENABLE_WIDTH = 4;

  // Boot loader
  localparam int unsigned NBF_DEPTH      = 8;
  localparam int unsigned NBF_IDX_WIDTH  = $clog2(NBF_DEPTH);
  localparam int unsigned NBF_PTR_WIDTH  = $clog2(NBF_DEPTH + 1);
  localparam int unsigned LOADER_CREDITS = 2;
  localparam int unsigned CREDIT_WIDTH   = $clog2(LOADER_CREDITS + 1);

  // Arbiter response steering FIFO
  localparam int unsigned SRC_FIFO_DEPTH = 4;
  localparam int unsigned SRC_PTR_WIDTH  = $clog2(SRC_FIFO_DEPTH);
  localparam int unsigned SRC_CNT_WIDTH  = $clog2(SRC_FIFO_DEPTH + 1);

endpackage

/* rtl/nbf_loader.sv */
/*
  Boot loader that replays NBF_DEPTH commands once after reset.
  The image is read from nbf_init.mem in the simulation run directory.
  At most LOADER_CREDITS commands are outstanding at any time.
  Response contents are ignored; the response port is always ready.
  done_o stays high until the next reset.
*/
`timescale 1ns/1ps

module nbf_loader (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  output bedrock_pkg::mem_msg_s ldr_cmd_o,
  output logic                  ldr_cmd_v_o,
  input  logic                  ldr_cmd_ready_and_i,
  input  bedrock_pkg::mem_msg_s ldr_resp_i,
  input  logic                  ldr_resp_v_i,
  output logic                  ldr_resp_ready_and_o,
  output logic                  done_o
);
  import bedrock_pkg::*;
  import host_map_pkg::*;

  mem_msg_s                 rom [NBF_DEPTH];
  logic [NBF_PTR_WIDTH-1:0] issue_ptr_r;
  logic [CREDIT_WIDTH-1:0]  pending_r;
  logic                     all_sent;
  logic                     cmd_hs;
  logic                     resp_hs;
  logic                     done_r;

  initial begin
    $readmemh("nbf_init.mem", rom);
  end

  assign all_sent    = issue_ptr_r == NBF_PTR_WIDTH'(NBF_DEPTH);
  // Hold off when every credit is in use
  assign ldr_cmd_v_o = ~all_sent & (pending_r != CREDIT_WIDTH'(LOADER_CREDITS));
  assign ldr_cmd_o   = rom[issue_ptr_r[NBF_IDX_WIDTH-1:0]];

  assign ldr_resp_ready_and_o = 1'b1;

  assign cmd_hs  = ldr_cmd_v_o & ldr_cmd_ready_and_i;
  assign resp_hs = ldr_resp_v_i & ldr_resp_ready_and_o;
  assign done_o  = done_r;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      issue_ptr_r <= '0;
      pending_r   <= '0;
      done_r      <= 1'b0;
    end else begin
      if (cmd_hs) begin
        issue_ptr_r <= issue_ptr_r + 1'b1;
      end
      case ({cmd_hs, resp_hs})
        2'b10:   pending_r <= pending_r + 1'b1;
        2'b01:   pending_r <= pending_r - 1'b1;
        default: pending_r <= pending_r;
      endcase
      // Last response of the list just came back
      if (all_sent & resp_hs & (pending_r == CREDIT_WIDTH'(1))) begin
        done_r <= 1'b1;
      end
    end
  end

endmodule

/* rtl/io_cmd_arbiter.sv */
/*
  Merges processor and loader commands onto one host link.
  Round-robin when both sources are valid, zero cycles on the command path.
  A small FIFO records the source of each accepted command so responses
  return to their issuer in command order. Grant stops while it is full.
  The FIFO holds SRC_FIFO_DEPTH commands in flight.
*/
`timescale 1ns/1ps

module io_cmd_arbiter (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  bedrock_pkg::mem_msg_s proc_cmd_i,
  input  logic                  proc_cmd_v_i,
  output logic                  proc_cmd_ready_and_o,
  input  bedrock_pkg::mem_msg_s ldr_cmd_i,
  input  logic                  ldr_cmd_v_i,
  output logic                  ldr_cmd_ready_and_o,
  output bedrock_pkg::mem_msg_s host_cmd_o,
  output logic                  host_cmd_v_o,
  input  logic                  host_cmd_ready_and_i,
  input  bedrock_pkg::mem_msg_s host_resp_i,
  input  logic                  host_resp_v_i,
  output logic                  host_resp_ready_and_o,
  output bedrock_pkg::mem_msg_s proc_resp_o,
  output logic                  proc_resp_v_o,
  input  logic                  proc_resp_ready_and_i,
  output bedrock_pkg::mem_msg_s ldr_resp_o,
  output logic                  ldr_resp_v_o,
  input  logic                  ldr_resp_ready_and_i
);
  import host_map_pkg::*;

  logic                     prio_ldr_r;
  logic                     grant_ldr;
  logic                     grant_proc;
  logic                     cmd_hs;
  logic                     resp_hs;
  logic                     src_q [SRC_FIFO_DEPTH];
  logic [SRC_PTR_WIDTH-1:0] wr_ptr_r;
  logic [SRC_PTR_WIDTH-1:0] rd_ptr_r;
  logic [SRC_CNT_WIDTH-1:0] count_r;
  logic                     fifo_full;
  logic                     fifo_empty;
  logic                     head_ldr;

  assign fifo_full  = count_r == SRC_CNT_WIDTH'(SRC_FIFO_DEPTH);
  assign fifo_empty = count_r == '0;

  // Loader wins when it holds priority or the processor is idle
  assign grant_ldr  = ldr_cmd_v_i & (prio_ldr_r | ~proc_cmd_v_i);
  assign grant_proc = proc_cmd_v_i & ~grant_ldr;

  assign host_cmd_o   = grant_ldr ? ldr_cmd_i : proc_cmd_i;
  assign host_cmd_v_o = (proc_cmd_v_i | ldr_cmd_v_i) & ~fifo_full;
  assign cmd_hs       = host_cmd_v_o & host_cmd_ready_and_i;

  assign proc_cmd_ready_and_o = grant_proc & ~fifo_full & host_cmd_ready_and_i;
  assign ldr_cmd_ready_and_o  = grant_ldr & ~fifo_full & host_cmd_ready_and_i;

  // Response goes to whoever issued the oldest outstanding command
  assign head_ldr      = src_q[rd_ptr_r];
  assign proc_resp_o   = host_resp_i;
  assign ldr_resp_o    = host_resp_i;
  assign proc_resp_v_o = host_resp_v_i & ~fifo_empty & ~head_ldr;
  assign ldr_resp_v_o  = host_resp_v_i & ~fifo_empty & head_ldr;
  assign host_resp_ready_and_o = ~fifo_empty
                               & (head_ldr ? ldr_resp_ready_and_i : proc_resp_ready_and_i);
  assign resp_hs = host_resp_v_i & host_resp_ready_and_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_ldr_r <= 1'b1;
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      count_r    <= '0;
    end else begin
      if (cmd_hs) begin
        prio_ldr_r <= ~grant_ldr;
        wr_ptr_r   <= wr_ptr_r + 1'b1;
      end
      if (resp_hs) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      case ({cmd_hs, resp_hs})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_hs) begin
      src_q[wr_ptr_r] <= grant_ldr;
    end
  end

endmodule

/* rtl/host_regs.sv */
/*
  Host register device on a single-beat memory link.
  Accepts a command only when its one-entry response buffer is empty,
  so the response is valid the cycle after the command transfer.
  Answers only to HOST_DEV_ID; other ids and unmapped indices read zero
  and leave state alone. Writes always return zero data.
  putchar_o is meaningful only while putchar_v_o is high.
*/
`timescale 1ns/1ps

module host_regs (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  bedrock_pkg::mem_msg_s                 cmd_i,
  input  logic                                  cmd_v_i,
  output logic                                  cmd_ready_and_o,
  output bedrock_pkg::mem_msg_s                 resp_o,
  output logic                                  resp_v_o,
  input  logic                                  resp_ready_and_i,
  output logic [host_map_pkg::NUM_CORE-1:0]     finish_o,
  output logic [host_map_pkg::ENABLE_WIDTH-1:0] enable_o,
  output logic [7:0]                            putchar_o,
  output logic                                  putchar_v_o
);
  import bedrock_pkg::*;
  import host_map_pkg::*;

  logic                      cmd_hs;
  logic                      resp_hs;
  logic                      is_wr;
  logic                      dev_hit;
  logic [REG_IDX_WIDTH-1:0]  reg_idx;
  logic [REG_IDX_WIDTH-1:0]  finish_off;
  logic [CORE_IDX_WIDTH-1:0] core_idx;
  logic                      finish_hit;
  logic                      enable_hit;
  logic                      putchar_hit;
  logic [DATA_WIDTH-1:0]     rd_data;
  logic                      resp_v_r;
  mem_msg_s                  resp_r;
  logic [NUM_CORE-1:0]       finish_r;
  logic [ENABLE_WIDTH-1:0]   enable_r;
  logic [7:0]                putchar_r;
  logic                      putchar_v_r;

  assign cmd_ready_and_o = ~resp_v_r;
  assign cmd_hs          = cmd_v_i & cmd_ready_and_o;
  assign resp_hs         = resp_v_r & resp_ready_and_i;
  assign is_wr           = cmd_i.header.op == e_mem_wr;

  // Decode through the field view of the address
  assign dev_hit     = cmd_i.header.addr.fields.dev_id == HOST_DEV_ID;
  assign reg_idx     = cmd_i.header.addr.fields.reg_idx;
  assign finish_off  = reg_idx - REG_FINISH_BASE;
  assign core_idx    = finish_off[CORE_IDX_WIDTH-1:0];
  assign finish_hit  = dev_hit & (finish_off < REG_IDX_WIDTH'(NUM_CORE));
  assign enable_hit  = dev_hit & (reg_idx == REG_ENABLE);
  assign putchar_hit = dev_hit & (reg_idx == REG_PUTCHAR);

  // Putchar and unmapped reads fall through as zero
  always_comb begin
    rd_data = '0;
    if (finish_hit) begin
      rd_data[0] = finish_r[core_idx];
    end else if (enable_hit) begin
      rd_data[ENABLE_WIDTH-1:0] = enable_r;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      finish_r    <= '0;
      enable_r    <= '0;
      putchar_v_r <= 1'b0;
      resp_v_r    <= 1'b0;
    end else begin
      putchar_v_r <= cmd_hs & is_wr & putchar_hit;
      if (cmd_hs & is_wr & finish_hit) begin
        finish_r[core_idx] <= cmd_i.data[0];
      end
      if (cmd_hs & is_wr & enable_hit) begin
        enable_r <= cmd_i.data[ENABLE_WIDTH-1:0];
      end
      if (cmd_hs) begin
        resp_v_r <= 1'b1;
      end else if (resp_hs) begin
        resp_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_hs) begin
      resp_r.header <= cmd_i.header;
      resp_r.data   <= is_wr ? '0 : rd_data;
    end
    if (cmd_hs & is_wr & putchar_hit) begin
      putchar_r <= cmd_i.data[7:0];
    end
  end

  assign resp_o      = resp_r;
  assign resp_v_o    = resp_v_r;
  assign finish_o    = finish_r;
  assign enable_o    = enable_r;
  assign putchar_o   = putchar_r;
  assign putchar_v_o = putchar_v_r;

endmodule

/* rtl/io_host_top.sv */
/*
  Host side I/O subsystem with boot loader, command arbiter and host device.
  The loader starts replaying its boot list right after reset and shares
  the host device with the processor port. done_o marks the end of boot.
  A lone processor command sees its response one cycle after transfer.
*/
`timescale 1ns/1ps

module io_host_top (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  bedrock_pkg::mem_msg_s                 proc_cmd_i,
  input  logic                                  proc_cmd_v_i,
  output logic                                  proc_cmd_ready_and_o,
  output bedrock_pkg::mem_msg_s                 proc_resp_o,
  output logic                                  proc_resp_v_o,
  input  logic                                  proc_resp_ready_and_i,
  output logic [host_map_pkg::NUM_CORE-1:0]     finish_o,
  output logic [host_map_pkg::ENABLE_WIDTH-1:0] enable_o,
  output logic [7:0]                            putchar_o,
  output logic                                  putchar_v_o,
  output logic                                  done_o
);
  import bedrock_pkg::*;

  mem_msg_s ldr_cmd;
  logic     ldr_cmd_v;
  logic     ldr_cmd_ready_and;
  mem_msg_s ldr_resp;
  logic     ldr_resp_v;
  logic     ldr_resp_ready_and;
  mem_msg_s host_cmd;
  logic     host_cmd_v;
  logic     host_cmd_ready_and;
  mem_msg_s host_resp;
  logic     host_resp_v;
  logic     host_resp_ready_and;

  nbf_loader loader (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .ldr_cmd_o            (ldr_cmd),
    .ldr_cmd_v_o          (ldr_cmd_v),
    .ldr_cmd_ready_and_i  (ldr_cmd_ready_and),
    .ldr_resp_i           (ldr_resp),
    .ldr_resp_v_i         (ldr_resp_v),
    .ldr_resp_ready_and_o (ldr_resp_ready_and),
    .done_o               (done_o)
  );

  io_cmd_arbiter arbiter (
    .clk_i                 (clk_i),
    .arst_n_i              (arst_n_i),
    .proc_cmd_i            (proc_cmd_i),
    .proc_cmd_v_i          (proc_cmd_v_i),
    .proc_cmd_ready_and_o  (proc_cmd_ready_and_o),
    .ldr_cmd_i             (ldr_cmd),
    .ldr_cmd_v_i           (ldr_cmd_v),
    .ldr_cmd_ready_and_o   (ldr_cmd_ready_and),
    .host_cmd_o            (host_cmd),
    .host_cmd_v_o          (host_cmd_v),
    .host_cmd_ready_and_i  (host_cmd_ready_and),
    .host_resp_i           (host_resp),
    .host_resp_v_i         (host_resp_v),
    .host_resp_ready_and_o (host_resp_ready_and),
    .proc_resp_o           (proc_resp_o),
    .proc_resp_v_o         (proc_resp_v_o),
    .proc_resp_ready_and_i (proc_resp_ready_and_i),
    .ldr_resp_o            (ldr_resp),
    .ldr_resp_v_o          (ldr_resp_v),
    .ldr_resp_ready_and_i  (ldr_resp_ready_and)
  );

  host_regs host (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cmd_i            (host_cmd),
    .cmd_v_i          (host_cmd_v),
    .cmd_ready_and_o  (host_cmd_ready_and),
    .resp_o           (host_resp),
    .resp_v_o         (host_resp_v),
    .resp_ready_and_i (host_resp_ready_and),
    .finish_o         (finish_o),
    .enable_o         (enable_o),
    .putchar_o        (putchar_o),
    .putchar_v_o      (putchar_v_o)
  );

endmodule

/* tests/io_host_assertions.sv */
/*
  Handshake and response steering properties for io_cmd_arbiter.
  Attached to every arbiter instance by bind. Checks are off during reset.
  The in-flight count is rebuilt here from the host link handshakes.
  fail_count counts failed assertions and is read at the end of the run.
*/
`timescale 1ns/1ps

module io_host_assertions (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input bedrock_pkg::mem_msg_s proc_cmd_i,
  input logic                  proc_cmd_v_i,
  input logic                  proc_cmd_ready_i,
  input bedrock_pkg::mem_msg_s ldr_cmd_i,
  input logic                  ldr_cmd_v_i,
  input logic                  ldr_cmd_ready_i,
  input logic                  host_cmd_v_i,
  input logic                  host_cmd_ready_i,
  input logic                  host_resp_v_i,
  input logic                  host_resp_ready_i,
  input logic                  proc_resp_v_i,
  input logic                  ldr_resp_v_i
);
  import host_map_pkg::*;

  int unsigned fail_count = 0;
  int          in_flight;

  // Commands taken by the host and not yet answered
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(host_cmd_v_i && host_cmd_ready_i)
                             - int'(host_resp_v_i && host_resp_ready_i);
    end
  end

  // Senders hold valid and message until the transfer
  proc_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    proc_cmd_v_i && !proc_cmd_ready_i |=> proc_cmd_v_i && $stable(proc_cmd_i))
    else begin
      $error("processor command dropped or changed before its transfer");
      fail_count++;
    end

  ldr_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ldr_cmd_v_i && !ldr_cmd_ready_i |=> ldr_cmd_v_i && $stable(ldr_cmd_i))
    else begin
      $error("loader command dropped or changed before its transfer");
      fail_count++;
    end

  // A response always has a recorded source
  no_resp_when_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (in_flight == 0) |-> !(host_resp_v_i || proc_resp_v_i || ldr_resp_v_i))
    else begin
      $error("response present while the source FIFO is empty");
      fail_count++;
    end

  no_grant_when_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (in_flight == SRC_FIFO_DEPTH) |-> !(proc_cmd_ready_i || ldr_cmd_ready_i || host_cmd_v_i))
    else begin
      $error("command granted while the source FIFO is full");
      fail_count++;
    end

endmodule

bind io_cmd_arbiter io_host_assertions props (
  .clk_i             (clk_i),
  .arst_n_i          (arst_n_i),
  .proc_cmd_i        (proc_cmd_i),
  .proc_cmd_v_i      (proc_cmd_v_i),
  .proc_cmd_ready_i  (proc_cmd_ready_and_o),
  .ldr_cmd_i         (ldr_cmd_i),
  .ldr_cmd_v_i       (ldr_cmd_v_i),
  .ldr_cmd_ready_i   (ldr_cmd_ready_and_o),
  .host_cmd_v_i      (host_cmd_v_o),
  .host_cmd_ready_i  (host_cmd_ready_and_i),
  .host_resp_v_i     (host_resp_v_i),
  .host_resp_ready_i (host_resp_ready_and_o),
  .proc_resp_v_i     (proc_resp_v_o),
  .ldr_resp_v_i      (ldr_resp_v_o)
);

/* tests/io_host_tb.sv */
/*
  Testbench for io_host_top with a register model driven by observed transfers.
  Loader commands are seen by peeking at the loader link inside uut.
  nbf_init.mem is read from the run directory, as the loader does.
  Two resets are applied: one for the plain boot and one for boot under load.
*/
`timescale 1ns/1ps

module io_host_tb;
  import bedrock_pkg::*;
  import host_map_pkg::*;

  localparam int N_MAP       = 40;
  localparam int N_CHAR      = 16;
  localparam int N_BAD       = 16;
  localparam int N_STALL     = 60;
  localparam int N_BOOT      = 12;
  localparam int TOTAL_CMDS  = 2 * NBF_DEPTH + N_MAP + N_CHAR + N_BAD + N_STALL + N_BOOT;
  localparam int CYCLE_LIMIT = 20 * TOTAL_CMDS;
  localparam int K_FINISH    = 0;
  localparam int K_ENABLE    = 1;
  localparam int K_PUTCHAR   = 2;
  localparam int K_NONE      = 3;

  logic                    clk_i;
  logic                    arst_n_i;
  mem_msg_s                proc_cmd_i;
  logic                    proc_cmd_v_i;
  logic                    proc_cmd_ready_and_o;
  mem_msg_s                proc_resp_o;
  logic                    proc_resp_v_o;
  logic                    proc_resp_ready_and_i;
  logic [NUM_CORE-1:0]     finish_o;
  logic [ENABLE_WIDTH-1:0] enable_o;
  logic [7:0]              putchar_o;
  logic                    putchar_v_o;
  logic                    done_o;

  integer                  seed = 32;
  int                      err_count = 0;
  int                      check_count = 0;
  int                      cycle_count = 0;
  int                      resp_count = 0;
  logic                    stall_en = 1'b0;
  logic [NUM_CORE-1:0]     sh_finish;
  logic [ENABLE_WIDTH-1:0] sh_enable;
  mem_msg_s                exp_resp [$];
  logic [7:0]              exp_chars [$];
  mem_msg_s                boot_img [NBF_DEPTH];

  io_host_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, a response or putchar never arrived", cycle_count);
    $display("Checks failed");
    $finish;
  end

  // Response back-pressure, random only while stall_en is set
  always @(posedge clk_i) begin : stall_drive
    logic ready_next;
    ready_next = stall_en ? ({$random(seed)} % 3 != 0) : 1'b1;
    #1;
    proc_resp_ready_and_i = ready_next;
  end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic note_failure(input string what);
    err_count++;
    $display("At %0t ns: %s", $time, what);
  endtask

  function automatic int reg_kind(input mem_addr_u addr);
    logic [REG_IDX_WIDTH-1:0] idx;
    idx = addr.fields.reg_idx;
    if (addr.fields.dev_id != HOST_DEV_ID) return K_NONE;
    if (idx >= REG_FINISH_BASE && idx < REG_FINISH_BASE + 12'(NUM_CORE)) return K_FINISH;
    if (idx == REG_ENABLE) return K_ENABLE;
    if (idx == REG_PUTCHAR) return K_PUTCHAR;
    return K_NONE;
  endfunction

  function automatic int core_of(input mem_addr_u addr);
    return int'(addr.fields.reg_idx - REG_FINISH_BASE);
  endfunction

  // Model update for one command, in host transfer order
  task automatic apply_cmd(input mem_msg_s cmd, input logic from_proc);
    mem_msg_s resp;
    logic     wr;
    wr          = cmd.header.op == e_mem_wr;
    resp.header = cmd.header;
    resp.data   = '0;
    case (reg_kind(cmd.header.addr))
      K_FINISH: begin
        if (wr) sh_finish[core_of(cmd.header.addr)] = cmd.data[0];
        else resp.data[0] = sh_finish[core_of(cmd.header.addr)];
      end
      K_ENABLE: begin
        if (wr) sh_enable = cmd.data[ENABLE_WIDTH-1:0];
        else resp.data[ENABLE_WIDTH-1:0] = sh_enable;
      end
      K_PUTCHAR: begin
        if (wr) exp_chars.push_back(cmd.data[7:0]);
      end
      default: ;
    endcase
    if (from_proc) exp_resp.push_back(resp);
  endtask

  task automatic replay_boot(output logic [NUM_CORE-1:0] fin,
                             output logic [ENABLE_WIDTH-1:0] en);
    int i;
    fin = '0;
    en  = '0;
    for (i = 0; i < NBF_DEPTH; i++) begin
      if (boot_img[i].header.op == e_mem_wr) begin
        if (reg_kind(boot_img[i].header.addr) == K_FINISH)
          fin[core_of(boot_img[i].header.addr)] = boot_img[i].data[0];
        else if (reg_kind(boot_img[i].header.addr) == K_ENABLE)
          en = boot_img[i].data[ENABLE_WIDTH-1:0];
      end
    end
  endtask

  // Mix 0 mapped regs, 1 putchar writes, 2 foreign or unmapped, 3 anything
  task automatic make_cmd(input int mix, output mem_msg_s cmd);
    int          pick;
    logic [3:0]  dev;
    logic [11:0] idx;
    pick = (mix == 3) ? {$random(seed)} % 3 : mix;
    dev  = HOST_DEV_ID;
    case (pick)
      0: idx = ({$random(seed)} % 2) ? REG_ENABLE
                                     : REG_FINISH_BASE + 12'({$random(seed)} % NUM_CORE);
      1: idx = REG_PUTCHAR;
      default: begin
        idx = 12'h100 | 12'({$random(seed)} % 256);
        // Foreign ids target mapped indices so only the id decode keeps them out
        if ({$random(seed)} % 2) begin
          dev = 4'($random(seed));
          if (dev == HOST_DEV_ID) dev = 4'hE;
          case ({$random(seed)} % 3)
            0: idx = REG_ENABLE;
            1: idx = REG_PUTCHAR;
            default: idx = REG_FINISH_BASE + 12'({$random(seed)} % NUM_CORE);
          endcase
        end
      end
    endcase
    cmd.header.op   = (mix == 1) ? e_mem_wr : mem_op_e'({$random(seed)} % 2);
    cmd.header.size = mem_size_e'({$random(seed)} % 3);
    cmd.header.addr.fields.dev_id  = dev;
    cmd.header.addr.fields.reg_idx = idx;
    cmd.header.addr.fields.offset  = 4'($random(seed));
    cmd.data = $random(seed);
  endtask

  // Called 1 ns after a rising edge, returns at the same point
  task automatic send_cmd(input mem_msg_s cmd);
    logic accepted;
    proc_cmd_i   = cmd;
    proc_cmd_v_i = 1'b1;
    accepted     = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = proc_cmd_ready_and_o;
      @(posedge clk_i);
      #1;
    end
    proc_cmd_v_i = 1'b0;
    if ({$random(seed)} % 4 == 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic run_cmds(input int count, input int mix);
    mem_msg_s cmd;
    int       n;
    for (n = 0; n < count; n++) begin
      make_cmd(mix, cmd);
      send_cmd(cmd);
    end
  endtask

  task automatic drain();
    while (exp_resp.size() != 0 || exp_chars.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    #1;
  endtask

  task automatic apply_reset();
    arst_n_i     = 1'b0;
    proc_cmd_v_i = 1'b0;
    sh_finish    = '0;
    sh_enable    = '0;
    resp_count   = 0;
    exp_resp.delete();
    exp_chars.delete();
    repeat (5) @(posedge clk_i);
    #1;
    check("done_o", '0, 64'(done_o));
    check("proc_resp_v_o", '0, 64'(proc_resp_v_o));
    check("putchar_v_o", '0, 64'(putchar_v_o));
    check("finish_o", '0, 64'(finish_o));
    check("enable_o", '0, 64'(enable_o));
    arst_n_i = 1'b1;
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    $display("Test %0d %s: %s", num, name, (err_count == errs_before) ? "PASS" : "FAIL");
  endtask

  // Outputs are stable at the falling edge, and a transfer seen here lands on the next rise
  always @(negedge clk_i) begin : monitor
    mem_msg_s expected;
    if (arst_n_i) begin
      check("finish_o", 64'(sh_finish), 64'(finish_o));
      check("enable_o", 64'(sh_enable), 64'(enable_o));
      if (putchar_v_o) begin
        if (exp_chars.size() == 0) note_failure("putchar pulse without a putchar write");
        else check("putchar_o", 64'(exp_chars.pop_front()), 64'(putchar_o));
      end
      if (proc_resp_v_o && proc_resp_ready_and_i) begin
        resp_count++;
        if (exp_resp.size() == 0) begin
          note_failure("processor response with no command outstanding");
        end else begin
          expected = exp_resp.pop_front();
          check("proc_resp_o.header", 64'(expected.header), 64'(proc_resp_o.header));
          check("proc_resp_o.data", 64'(expected.data), 64'(proc_resp_o.data));
        end
      end
      if (proc_cmd_v_i && proc_cmd_ready_and_o) apply_cmd(proc_cmd_i, 1'b1);
      if (uut.ldr_cmd_v && uut.ldr_cmd_ready_and) apply_cmd(uut.ldr_cmd, 1'b0);
    end
  end

  initial begin : main
    logic [NUM_CORE-1:0]     boot_fin;
    logic [ENABLE_WIDTH-1:0] boot_en;
    logic [NUM_CORE-1:0]     hold_fin;
    logic [ENABLE_WIDTH-1:0] hold_en;
    int                      mark;
    arst_n_i              = 1'b0;
    proc_cmd_i            = '0;
    proc_cmd_v_i          = 1'b0;
    proc_resp_ready_and_i = 1'b1;
    $readmemh("nbf_init.mem", boot_img);
    replay_boot(boot_fin, boot_en);

    mark = err_count;
    apply_reset();
    wait (done_o);
    @(posedge clk_i);
    #1;
    check("finish_o after boot", 64'(boot_fin), 64'(finish_o));
    check("enable_o after boot", 64'(boot_en), 64'(enable_o));
    drain();
    report_test(1, "boot replay", mark);

    mark = err_count;
    run_cmds(N_MAP, 0);
    drain();
    report_test(2, "finish and enable access", mark);

    mark = err_count;
    run_cmds(N_CHAR, 1);
    drain();
    report_test(3, "putchar stream", mark);

    mark = err_count;
    hold_fin = finish_o;
    hold_en  = enable_o;
    run_cmds(N_BAD, 2);
    drain();
    check("finish_o unchanged", 64'(hold_fin), 64'(finish_o));
    check("enable_o unchanged", 64'(hold_en), 64'(enable_o));
    report_test(4, "foreign and unmapped", mark);

    mark = err_count;
    resp_count = 0;
    stall_en = 1'b1;
    run_cmds(N_STALL, 3);
    drain();
    stall_en = 1'b0;
    check("responses under stall", 64'(N_STALL), 64'(resp_count));
    report_test(5, "response back-pressure", mark);

    mark = err_count;
    apply_reset();
    run_cmds(N_BOOT, 3);
    drain();
    wait (done_o);
    @(posedge clk_i);
    #1;
    check("responses during boot", 64'(N_BOOT), 64'(resp_count));
    report_test(6, "traffic during boot", mark);

    err_count += uut.arbiter.props.fail_count;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             check_count, err_count, uut.arbiter.props.fail_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* nbf_init.mem */
// Boot list, one message per line as 14 hex digits: op/size nibble,
// 20-bit address (device, register index, offset), 32-bit data
61020000000005
61010000000001
61012000000001
21020000000000
61030000000042
61012000000000
6102000000000A
61013000000001

/* sim.f */
rtl/bedrock_pkg.sv
rtl/host_map_pkg.sv
rtl/nbf_loader.sv
rtl/io_cmd_arbiter.sv
rtl/host_regs.sv
rtl/io_host_top.sv
tests/io_host_assertions.sv
tests/io_host_tb.sv

/* Makefile */
# Verilator build and run for the host I/O subsystem testbench

VERILATOR ?= verilator
TOP       ?= io_host_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
SOURCES   := $(wildcard rtl/*.sv tests/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP) nbf_init.mem
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG) || ! grep -q "All checks passed" $(LOG); then \
	  echo "Result: FAIL"; exit 1; \
	else \
	  echo "Result: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
